// File: hdl/rv32i_types.sv
package rv32i_types;

    // Datapath width of the RV32I core
    localparam int XLEN = 32;

    // Physical register tag width, giving 64 registers
    localparam int PHYS_REG_BITS = 6;
    localparam int PHYS_REG_COUNT = 1 << PHYS_REG_BITS;

    // ROB index, carried through execute for retire
    localparam int ROB_ID_BITS = 3;

    // ALU operations
    // Low three bits follow funct3, bit 3 marks sub and sra
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // Branch compares, encoded as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    // Operand select
    // Operand 1: reg, immediate, PC
    // Operand 2: reg, zero, immediate
    // Code 2'b10 is never issued
    typedef enum logic [1:0] {
        opsel_reg      = 2'b00,
        opsel_imm_zero = 2'b01,
        opsel_pc_imm   = 2'b11
    } operand_sel_t;

    // Decoded instruction as held in a reservation station entry
    typedef struct packed {
        logic [XLEN-1:0]          pc;
        logic [XLEN-1:0]          immediate;
        alu_op_t                  alu_operation;
        cmp_op_t                  cmp_operation;
        operand_sel_t             execute_operand1;
        operand_sel_t             execute_operand2;
        logic                     is_branch;
        logic [ROB_ID_BITS-1:0]   rob_id;
        logic [PHYS_REG_BITS-1:0] pd;
        logic [PHYS_REG_BITS-1:0] ps1;
        logic [PHYS_REG_BITS-1:0] ps2;
    } inst_info_t;

    // One issue slot, valid is a single-cycle strobe
    typedef struct packed {
        logic       valid;
        inst_info_t inst_info;
    } fu_input_t;

    // Source operand values returned for one lane
    typedef struct packed {
        logic [XLEN-1:0] rs1_value;
        logic [XLEN-1:0] rs2_value;
    } reg_read_t;

    // Common data bus broadcast
    typedef struct packed {
        logic                     valid;
        logic [ROB_ID_BITS-1:0]   rob_id;
        logic [PHYS_REG_BITS-1:0] pd;
        logic [XLEN-1:0]          register_value;
        logic                     is_branch;
        logic                     br_taken;
        logic [XLEN-1:0]          br_target;
    } cdb_t;

endpackage : rv32i_types

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv32i_types::alu_op_t aluop,
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    output logic [31:0]          f
);
    import rv32i_types::*;

    // Shift amount comes from the low five bits of b only
    logic [4:0] shamt;

    // Set-less-than results before zero extension
    logic lt_signed;
    logic lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        unique case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            // slt and sltu give 0 or 1
            alu_slt:  f = {31'b0, lt_signed};
            alu_sltu: f = {31'b0, lt_unsigned};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            // Arithmetic shift keeps the sign of a
            alu_sra:  f = $unsigned($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            // Encodings outside the enum
            default:  f = '0;
        endcase
    end

endmodule : alu

// File: hdl/cmp.sv
`timescale 1ns/1ps

module cmp (
    input  rv32i_types::cmp_op_t cmpop,
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    output logic                 br_en
);
    import rv32i_types::*;

    // Shared compare terms
    logic equal;
    logic lt_signed;
    logic lt_unsigned;

    assign equal       = (a == b);
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        unique case (cmpop)
            cmp_beq:  br_en = equal;
            cmp_bne:  br_en = !equal;
            cmp_blt:  br_en = lt_signed;
            cmp_bge:  br_en = !lt_signed;
            cmp_bltu: br_en = lt_unsigned;
            cmp_bgeu: br_en = !lt_unsigned;
            // Unused funct3 codes never branch
            default:  br_en = 1'b0;
        endcase
    end

endmodule : cmp

// File: hdl/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile #(
    parameter int SS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  rv32i_types::fu_input_t issue    [SS],
    input  rv32i_types::cdb_t      cdb      [SS],
    output rv32i_types::reg_read_t reg_data [SS]
);
    import rv32i_types::*;

    // Physical register storage, entry 0 is never written
    logic [XLEN-1:0] regs [PHYS_REG_COUNT];

    // Per CDB lane, this broadcast writes a register
    logic cdb_wr [SS];

    // Branches carry no register result, p0 is read-only
    always_comb begin
        for (int j = 0; j < SS; j++) begin
            cdb_wr[j] = cdb[j].valid && !cdb[j].is_branch && (cdb[j].pd != '0);
        end
    end

    // Read ports, two per lane
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            // Stored values first
            reg_data[i].rs1_value = regs[issue[i].inst_info.ps1];
            reg_data[i].rs2_value = regs[issue[i].inst_info.ps2];

            // Same-cycle CDB results override the array
            for (int j = 0; j < SS; j++) begin
                if (cdb_wr[j] && (cdb[j].pd == issue[i].inst_info.ps1)) begin
                    reg_data[i].rs1_value = cdb[j].register_value;
                end
                if (cdb_wr[j] && (cdb[j].pd == issue[i].inst_info.ps2)) begin
                    reg_data[i].rs2_value = cdb[j].register_value;
                end
            end

            // p0 is hard-wired to zero
            if (issue[i].inst_info.ps1 == '0) begin
                reg_data[i].rs1_value = '0;
            end
            if (issue[i].inst_info.ps2 == '0) begin
                reg_data[i].rs2_value = '0;
            end
        end
    end

    // Write-back from every CDB lane
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < PHYS_REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int j = 0; j < SS; j++) begin
                if (cdb_wr[j]) begin
                    regs[cdb[j].pd] <= cdb[j].register_value;
                end
            end
        end
    end

    // Rename hands out each pd once, so two lanes never write one register
    for (genvar a = 0; a < SS; a++) begin : g_wr_pair_a
        for (genvar b = a + 1; b < SS; b++) begin : g_wr_pair_b
            assert property (@(posedge clk) disable iff (reset)
                !(cdb_wr[a] && cdb_wr[b] && (cdb[a].pd == cdb[b].pd)))
            else $error("phys_regfile: CDB lanes %0d and %0d write p%0d together",
                        a, b, cdb[a].pd);
        end
    end

endmodule : phys_regfile

// File: hdl/fu_wrapper.sv
`timescale 1ns/1ps

module fu_wrapper #(
    parameter int SS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  rv32i_types::fu_input_t issue       [SS],
    input  rv32i_types::reg_read_t fu_reg_data [SS],
    output rv32i_types::cdb_t      cdb         [SS]
);
    import rv32i_types::*;

    // Form     | operand 1 | operand 2
    // R-type   | rs1       | rs2
    // I-type   | rs1       | immediate
    // U-type   | immediate | zero
    // B-type   | PC        | immediate, compare on rs1 and rs2

    // ALU operands after select
    logic [XLEN-1:0] alu_input_a [SS];
    logic [XLEN-1:0] alu_input_b [SS];

    // Operation fed to each ALU
    alu_op_t         alu_operation [SS];

    // Functional unit outputs
    logic [XLEN-1:0] alu_output [SS];
    logic            cmp_output [SS];

    // Next and held lane results
    cdb_t            result_d [SS];
    cdb_t            result_q [SS];
    logic            valid_q  [SS];

    // Operand select
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            unique case (issue[i].inst_info.execute_operand1)
                opsel_reg:      alu_input_a[i] = fu_reg_data[i].rs1_value;
                opsel_imm_zero: alu_input_a[i] = issue[i].inst_info.immediate;
                opsel_pc_imm:   alu_input_a[i] = issue[i].inst_info.pc;
                default:        alu_input_a[i] = '0;
            endcase
            unique case (issue[i].inst_info.execute_operand2)
                opsel_reg:      alu_input_b[i] = fu_reg_data[i].rs2_value;
                opsel_imm_zero: alu_input_b[i] = '0;
                opsel_pc_imm:   alu_input_b[i] = issue[i].inst_info.immediate;
                default:        alu_input_b[i] = '0;
            endcase
            // Branch target is always PC plus immediate
            alu_operation[i] = issue[i].inst_info.is_branch ? alu_add
                                                            : issue[i].inst_info.alu_operation;
        end
    end

    // One ALU and one comparator per lane
    for (genvar i = 0; i < SS; i++) begin : g_lane
        alu alu_inst (
            .aluop (alu_operation[i]),
            .a     (alu_input_a[i]),
            .b     (alu_input_b[i]),
            .f     (alu_output[i])
        );
        // Comparator sees the register values, never the selected operands
        cmp cmp_inst (
            .cmpop (issue[i].inst_info.cmp_operation),
            .a     (fu_reg_data[i].rs1_value),
            .b     (fu_reg_data[i].rs2_value),
            .br_en (cmp_output[i])
        );

        // Lane must never see the reserved select code
        assert property (@(posedge clk) disable iff (reset)
            issue[i].valid |-> (issue[i].inst_info.execute_operand1 != 2'b10) &&
                               (issue[i].inst_info.execute_operand2 != 2'b10))
        else $error("fu_wrapper: lane %0d issued with operand select 2'b10", i);
    end

    // Shape the broadcast
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            result_d[i].valid     = issue[i].valid;
            result_d[i].rob_id    = issue[i].inst_info.rob_id;
            result_d[i].pd        = issue[i].inst_info.pd;
            result_d[i].is_branch = issue[i].inst_info.is_branch;
            // Branches write nothing, so the value is zero
            result_d[i].register_value = issue[i].inst_info.is_branch ? '0 : alu_output[i];
            result_d[i].br_taken  = issue[i].inst_info.is_branch && cmp_output[i];
            result_d[i].br_target = alu_output[i];
        end
    end

    // Valid pulse, one cycle after issue
    always_ff @(posedge clk) begin
        for (int i = 0; i < SS; i++) begin
            if (reset) begin
                valid_q[i] <= 1'b0;
            end else begin
                valid_q[i] <= issue[i].valid;
            end
        end
    end

    // Payload only moves on an issue
    always_ff @(posedge clk) begin
        for (int i = 0; i < SS; i++) begin
            if (issue[i].valid) begin
                result_q[i] <= result_d[i];
            end
        end
    end

    // CDB output, valid from the reset-cleared flop
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            cdb[i]       = result_q[i];
            cdb[i].valid = valid_q[i];
        end
    end

endmodule : fu_wrapper

// File: hdl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit #(
    parameter int SS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    // Up to SS issues per cycle, one per lane
    input  rv32i_types::fu_input_t issue [SS],
    // Registered results, one cycle after issue
    output rv32i_types::cdb_t      cdb   [SS]
);
    import rv32i_types::*;

    // Source operands per lane, combinational from the register file
    reg_read_t reg_data [SS];

    // Operand reads and CDB write-back
    // The CDB loops back for writes and same-cycle forwarding
    phys_regfile #(
        .SS (SS)
    ) phys_regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .cdb      (cdb),
        .reg_data (reg_data)
    );

    // Operand select, ALU, compare and result registers
    fu_wrapper #(
        .SS (SS)
    ) fu_wrapper_inst (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .fu_reg_data (reg_data),
        .cdb         (cdb)
    );

endmodule : execute_unit

// File: tb/execute_unit_tb.sv
`timescale 1ns/1ps

module execute_unit_tb;
    import rv32i_types::*;

    localparam int lanes = 2;
    localparam int clk_period = 40;
    localparam int reset_cycles = 8;
    // Issue counts of the reset, ALU op, imm/PC, branch and dual lane tests
    localparam int total_issues = 4 + 40 + 12 + 97 + 6;
    localparam int timeout_cycles = total_issues * 4 + reset_cycles;

    logic        clk;
    logic        reset;
    fu_input_t   issue [lanes];
    cdb_t        cdb   [lanes];

    // Reference copy of the 64 physical registers
    logic [31:0] model_regs [64];
    logic [2:0]  rob_ctr;

    execute_unit #(
        .SS (lanes)
    ) execute_unit_inst (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .cdb   (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog sized from the issue count of all tests
    initial begin
        #(timeout_cycles * clk_period);
        $display("Timeout: the simulation timed out before all tests finished");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    // Signed less-than from the sign bits and the unsigned compare
    function automatic logic signed_less(logic [31:0] a, logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] model_alu(alu_op_t op, logic [31:0] a, logic [31:0] b);
        logic [63:0] ext;
        logic [4:0]  sh;
        sh = b[4:0];
        // Sign-extended copy for sra
        ext = {{32{a[31]}}, a} >> sh;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << sh;
            alu_slt:  return {31'b0, signed_less(a, b)};
            alu_sltu: return {31'b0, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> sh;
            alu_sra:  return ext[31:0];
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic model_cmp(cmp_op_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            cmp_beq:  return a == b;
            cmp_bne:  return a != b;
            cmp_blt:  return signed_less(a, b);
            cmp_bge:  return !signed_less(a, b);
            cmp_bltu: return a < b;
            default:  return !(a < b);
        endcase
    endfunction

    function automatic logic [31:0] read_model(logic [5:0] tag);
        return (tag == 6'd0) ? 32'd0 : model_regs[tag];
    endfunction

    function automatic inst_info_t make_inst(alu_op_t op, operand_sel_t s1, operand_sel_t s2,
                                             logic [5:0] pd, logic [5:0] ps1, logic [5:0] ps2,
                                             logic [31:0] pc, logic [31:0] imm);
        inst_info_t inst;
        inst = '0;
        inst.alu_operation = op;
        inst.cmp_operation = cmp_beq;
        inst.execute_operand1 = s1;
        inst.execute_operand2 = s2;
        inst.pd = pd;
        inst.ps1 = ps1;
        inst.ps2 = ps2;
        inst.pc = pc;
        inst.immediate = imm;
        return inst;
    endfunction

    // Expected broadcast from the operand-select and result rules
    function automatic cdb_t expect_result(inst_info_t inst);
        cdb_t        exp;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [31:0] res;
        rs1 = read_model(inst.ps1);
        rs2 = read_model(inst.ps2);
        opa = (inst.execute_operand1 == opsel_reg) ? rs1 :
              (inst.execute_operand1 == opsel_imm_zero) ? inst.immediate : inst.pc;
        opb = (inst.execute_operand2 == opsel_reg) ? rs2 :
              (inst.execute_operand2 == opsel_imm_zero) ? 32'd0 : inst.immediate;
        res = model_alu(inst.is_branch ? alu_add : inst.alu_operation, opa, opb);
        exp.valid = 1'b1;
        exp.rob_id = inst.rob_id;
        exp.pd = inst.pd;
        exp.is_branch = inst.is_branch;
        exp.register_value = inst.is_branch ? 32'd0 : res;
        exp.br_taken = inst.is_branch && model_cmp(inst.cmp_operation, rs1, rs2);
        exp.br_target = res;
        return exp;
    endfunction

    // Only a valid non-branch result with a nonzero pd is written back
    task automatic commit_model(input cdb_t exp);
        if (exp.valid && !exp.is_branch && (exp.pd != 6'd0)) begin
            model_regs[exp.pd] = exp.register_value;
        end
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else begin
            $display("error: %s %s expected 0x%08h actual 0x%08h", test, field, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_cdb(input string test, input int lane, input cdb_t exp);
        check_value(test, "valid", 32'(exp.valid), 32'(cdb[lane].valid));
        check_value(test, "rob_id", 32'(exp.rob_id), 32'(cdb[lane].rob_id));
        check_value(test, "pd", 32'(exp.pd), 32'(cdb[lane].pd));
        check_value(test, "is_branch", 32'(exp.is_branch), 32'(cdb[lane].is_branch));
        check_value(test, "register_value", exp.register_value, cdb[lane].register_value);
        check_value(test, "br_taken", 32'(exp.br_taken), 32'(cdb[lane].br_taken));
        if (exp.is_branch) begin
            check_value(test, "br_target", exp.br_target, cdb[lane].br_target);
        end
    endtask

    task automatic stamp_rob(inout inst_info_t inst);
        inst.rob_id = rob_ctr;
        rob_ctr = rob_ctr + 3'd1;
    endtask

    // One issue on one lane with its result checked one cycle later
    task automatic run_single(input string test, input int lane, input inst_info_t inst);
        cdb_t exp;
        stamp_rob(inst);
        exp = expect_result(inst);
        @(posedge clk);
        issue[lane].inst_info <= inst;
        issue[lane].valid <= 1'b1;
        @(posedge clk);
        issue[lane].valid <= 1'b0;
        @(negedge clk);
        check_cdb(test, lane, exp);
        commit_model(exp);
    endtask

    // Load is add with immediate on operand 1 and zero on operand 2
    task automatic load_reg(input string test, input int lane, input logic [5:0] pd,
                            input logic [31:0] value);
        run_single(test, lane, make_inst(alu_add, opsel_imm_zero, opsel_imm_zero,
                                         pd, 6'd0, 6'd0, 32'd0, value));
    endtask

    task automatic readback(input string test, input int lane, input logic [5:0] src,
                            input logic [5:0] dst);
        run_single(test, lane, make_inst(alu_add, opsel_reg, opsel_reg,
                                         dst, src, 6'd0, 32'd0, 32'd0));
    endtask

    task automatic reset_check();
        string test = "reset_check";
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_value(test, "cdb0 valid in reset", 32'd0, 32'(cdb[0].valid));
            check_value(test, "cdb1 valid in reset", 32'd0, 32'(cdb[1].valid));
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(test, "cdb0 valid after reset", 32'd0, 32'(cdb[0].valid));
        check_value(test, "cdb1 valid after reset", 32'd0, 32'(cdb[1].valid));
        load_reg(test, 0, 6'd1, $urandom);
        readback(test, 1, 6'd1, 6'd2);
        // A write aimed at p0 is dropped
        load_reg(test, 0, 6'd0, $urandom);
        readback(test, 1, 6'd0, 6'd3);
    endtask

    task automatic alu_ops_test();
        alu_op_t alu_list [10];
        alu_list = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                     alu_xor, alu_srl, alu_sra, alu_or, alu_and};
        for (int k = 0; k < 10; k++) begin
            load_reg("alu_ops_test", 0, 6'd10, $urandom);
            load_reg("alu_ops_test", 1, 6'd11, $urandom);
            run_single("alu_ops_test", k % 2, make_inst(alu_list[k], opsel_reg, opsel_reg,
                                                        6'd12, 6'd10, 6'd11, 32'd0, 32'd0));
            readback("alu_ops_test", (k + 1) % 2, 6'd12, 6'd13);
        end
    endtask

    task automatic imm_pc_test();
        for (int k = 0; k < 3; k++) begin
            load_reg("imm_pc_test", k % 2, 6'd5, $urandom);
            // I-type adds a register and the immediate
            run_single("imm_pc_test", 0, make_inst(alu_add, opsel_reg, opsel_pc_imm,
                                                   6'd6, 6'd5, 6'd0, 32'd0, $urandom));
            // U-type takes the immediate plus zero
            run_single("imm_pc_test", 1, make_inst(alu_add, opsel_imm_zero, opsel_imm_zero,
                                                   6'd7, 6'd0, 6'd0, 32'd0, $urandom));
            // PC-relative
            run_single("imm_pc_test", k % 2, make_inst(alu_add, opsel_pc_imm, opsel_pc_imm,
                                                       6'd8, 6'd0, 6'd0,
                                                       $urandom & 32'hffff_fffc, $urandom));
        end
    endtask

    task automatic branch_test();
        cmp_op_t     cmp_list [6];
        inst_info_t  inst;
        logic [31:0] a;
        logic [31:0] b;
        cmp_list = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu};
        // Branch pd holds a known value that must survive
        load_reg("branch_test", 0, 6'd30, $urandom);
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 4; k++) begin
                case (k)
                    0: begin
                        a = $urandom;
                        b = a;
                    end
                    // Less when signed and greater when unsigned
                    1: begin
                        a = $urandom | 32'h8000_0000;
                        b = $urandom & 32'h7fff_ffff;
                    end
                    // Greater when signed and less when unsigned
                    2: begin
                        a = $urandom & 32'h7fff_ffff;
                        b = $urandom | 32'h8000_0000;
                    end
                    default: begin
                        b = $urandom & 32'h3fff_ffff;
                        a = b + 32'd1 + ($urandom & 32'h0000_ffff);
                    end
                endcase
                load_reg("branch_test", 0, 6'd20, a);
                load_reg("branch_test", 1, 6'd21, b);
                // The target must still be PC plus immediate under another ALU code
                inst = make_inst(alu_sub, opsel_pc_imm, opsel_pc_imm, 6'd30, 6'd20, 6'd21,
                                 $urandom & 32'hffff_fffc, $urandom & 32'hffff_fffe);
                inst.is_branch = 1'b1;
                inst.cmp_operation = cmp_list[c];
                run_single("branch_test", (c + k) % 2, inst);
                readback("branch_test", 1, 6'd30, 6'd31);
            end
        end
    endtask

    task automatic dual_lane_test();
        string      test = "dual_lane_test";
        inst_info_t first [2];
        inst_info_t dep   [2];
        cdb_t       exp_first [2];
        cdb_t       exp_dep   [2];
        load_reg(test, 0, 6'd40, $urandom);
        load_reg(test, 1, 6'd41, $urandom);
        first[0] = make_inst(alu_sub, opsel_reg, opsel_reg, 6'd42, 6'd40, 6'd41, 32'd0, 32'd0);
        first[1] = make_inst(alu_xor, opsel_reg, opsel_reg, 6'd43, 6'd40, 6'd41, 32'd0, 32'd0);
        // Dependents read p42 and p43 while they are on the CDB
        dep[0] = make_inst(alu_add, opsel_reg, opsel_reg, 6'd44, 6'd42, 6'd43, 32'd0, 32'd0);
        dep[1] = make_inst(alu_sll, opsel_reg, opsel_reg, 6'd45, 6'd42, 6'd41, 32'd0, 32'd0);
        for (int i = 0; i < 2; i++) begin
            stamp_rob(first[i]);
            exp_first[i] = expect_result(first[i]);
        end
        for (int i = 0; i < 2; i++) begin
            commit_model(exp_first[i]);
        end
        for (int i = 0; i < 2; i++) begin
            stamp_rob(dep[i]);
            exp_dep[i] = expect_result(dep[i]);
        end
        @(posedge clk);
        issue[0].inst_info <= first[0];
        issue[1].inst_info <= first[1];
        issue[0].valid <= 1'b1;
        issue[1].valid <= 1'b1;
        @(posedge clk);
        issue[0].inst_info <= dep[0];
        issue[1].inst_info <= dep[1];
        @(negedge clk);
        check_cdb(test, 0, exp_first[0]);
        check_cdb(test, 1, exp_first[1]);
        @(posedge clk);
        issue[0].valid <= 1'b0;
        issue[1].valid <= 1'b0;
        @(negedge clk);
        check_cdb(test, 0, exp_dep[0]);
        check_cdb(test, 1, exp_dep[1]);
        commit_model(exp_dep[0]);
        commit_model(exp_dep[1]);
    endtask

    initial begin
        void'($urandom(32'h54d3782f));
        reset = 1'b1;
        rob_ctr = 3'd0;
        for (int i = 0; i < lanes; i++) begin
            issue[i] = '0;
        end
        for (int r = 0; r < 64; r++) begin
            model_regs[r] = 32'd0;
        end
        reset_check();
        alu_ops_test();
        imm_pc_test();
        branch_test();
        dual_lane_test();
        @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : execute_unit_tb

// File: list.f
hdl/rv32i_types.sv
hdl/alu.sv
hdl/cmp.sv
hdl/phys_regfile.sv
hdl/fu_wrapper.sv
hdl/execute_unit.sv
tb/execute_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module execute_unit_tb \
    -f list.f \
    -o sim_exe \
    && ./obj_dir/sim_exe 2>&1 | tee "$log" \
    || { echo "Build or run failed"; exit 1; }

# The log decides the result
grep -q "^Simulation finished: PASS$" "$log" && echo "Result: passed" \
    || { echo "Result: failed"; exit 1; }
